/* sources.f */
+incdir+.
memory_pkg.sv
cache_controller.sv
lane_mask_builder.sv
cache_tags.sv
cache_data.sv
memory_system.sv
tb_memory_system.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_memory_system -f sources.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_memory_system)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q -F '*** TEST PASSED ***'; then
	exit 0
fi
exit 1

/* tb_memory_system.sv */
`timescale 1ns/1ps
`include "memory_settings.svh"

module tb_memory_system;

	localparam int PERIOD = 40;
	localparam int FILL_DELAY = 5; // memory answers a line read after this many cycles
	localparam int ACCESSES = 24;
	localparam int MISS_CYCLES = 14; // idle, lookup, write-back, fill wait, retry and ack
	localparam int ACK_LIMIT = 4 * MISS_CYCLES;
	localparam int FETCH_PORT = `EXEC_PORTS;
	localparam int LINES = 1 << $bits(memory_pkg::line_addr_t);

	logic main_clk;
	logic rst_n;
	memory_pkg::exec_req_t exec_req [`EXEC_PORTS];
	logic ifetch_requesting;
	memory_pkg::byte_addr_t ifetch_address;
	logic [`EXEC_PORTS-1:0] exec_ack;
	logic [`EXEC_PORTS-1:0] exec_will_ack;
	logic ifetch_ack;
	memory_pkg::line_t rd_line;
	memory_pkg::mem_cmd_t mem_cmd;
	logic fill_valid;
	memory_pkg::line_t fill_line;

	memory_pkg::line_t mem_lines [LINES]; // backing memory
	memory_pkg::line_t exp_lines [LINES]; // memory as the executers should see it
	memory_pkg::line_t ack_line; // rd_line taken in the last acknowledge cycle
	logic [31:0] lcg_state;
	int errors;
	int rd_count;
	int wr_count;
	memory_pkg::line_addr_t last_rd_addr;
	memory_pkg::line_addr_t last_wr_addr;
	memory_pkg::line_t last_wr_line;

	memory_system dut0 (
		.main_clk(main_clk),
		.rst_n(rst_n),
		.exec_req(exec_req),
		.ifetch_requesting(ifetch_requesting),
		.ifetch_address(ifetch_address),
		.exec_ack(exec_ack),
		.exec_will_ack(exec_will_ack),
		.ifetch_ack(ifetch_ack),
		.rd_line(rd_line),
		.mem_cmd(mem_cmd),
		.fill_valid(fill_valid),
		.fill_line(fill_line)
	);

	initial begin
		main_clk = 1'b0;
		forever #(PERIOD / 2) main_clk = ~main_clk;
	end

	function automatic memory_pkg::word_t rand_word();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	// what a write must leave in the line, from the access rules
	task automatic expect_write(input memory_pkg::byte_addr_t addr, input logic byte_op,
			input logic is_stack, input logic [2:0] size, input logic [63:0] data);
		int word_idx;
		word_idx = int'(addr[3:1]);
		if (is_stack) begin
			for (int k = 0; k < int'(size); k++) begin
				exp_lines[addr[15:4]][(word_idx + k) * 16 +: 16] = data[k * 16 +: 16];
			end
		end else if (byte_op) begin
			exp_lines[addr[15:4]][word_idx * 16 + (addr[0] ? 8 : 0) +: 8] = data[7:0];
		end else begin
			exp_lines[addr[15:4]][word_idx * 16 +: 16] = data[15:0];
		end
	endtask

	// line port model, strobes sampled mid-cycle
	initial begin : backing_memory
		int wait_cycles;
		memory_pkg::line_addr_t pending;
		wait_cycles = 0;
		pending = '0;
		forever begin
			@(negedge main_clk);
			if (mem_cmd.wr) begin
				mem_lines[mem_cmd.line_addr] = mem_cmd.line;
				last_wr_addr = mem_cmd.line_addr;
				last_wr_line = mem_cmd.line;
				wr_count++;
			end
			if (mem_cmd.rd) begin
				pending = mem_cmd.line_addr;
				last_rd_addr = mem_cmd.line_addr;
				rd_count++;
				wait_cycles = FILL_DELAY;
			end
			@(posedge main_clk);
			#2;
			fill_valid = 1'b0;
			if (wait_cycles > 0) begin
				wait_cycles--;
				if (wait_cycles == 0) begin
					fill_valid = 1'b1;
					fill_line = mem_lines[pending];
				end
			end
		end
	end

	initial begin : watchdog
		#((16 + ACCESSES * MISS_CYCLES + 100) * PERIOD);
		$display("watchdog expired before the tests finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

	task automatic raise_request(input int port, input logic write, input logic byte_op,
			input logic is_stack, input logic [2:0] size, input memory_pkg::byte_addr_t addr,
			input logic [63:0] data);
		if (port == FETCH_PORT) begin
			ifetch_requesting = 1'b1;
			ifetch_address = addr;
		end else begin
			exec_req[port].requesting = 1'b1;
			exec_req[port].write = write;
			exec_req[port].byte_op = byte_op;
			exec_req[port].is_stack = is_stack;
			exec_req[port].stack_size = size;
			exec_req[port].address = addr;
			exec_req[port].data = data;
		end
		if (write) expect_write(addr, byte_op, is_stack, size, data);
	endtask

	task automatic drop_request(input int port);
		if (port == FETCH_PORT) ifetch_requesting = 1'b0;
		else exec_req[port] = '0;
	endtask

	task automatic check_ack(input int port, input logic [`EXEC_PORTS:0] acks,
			input logic [`EXEC_PORTS-1:0] prev_will, input memory_pkg::byte_addr_t addr);
		logic [`EXEC_PORTS:0] want;
		want = '0;
		want[port] = 1'b1;
		ack_line = rd_line;
		if (acks != want) begin
			$display("[FAIL] {ifetch_ack, exec_ack} got %h expected %h", acks, want);
			errors++;
		end
		if (port < FETCH_PORT && !prev_will[port]) begin
			$display("exec_will_ack of port %0d did not come one cycle before its ack", port);
			errors++;
		end
		if (rd_line !== exp_lines[addr[15:4]]) begin
			$display("[FAIL] rd_line at %h got %h expected %h", addr, rd_line,
				exp_lines[addr[15:4]]);
			errors++;
		end
	endtask

	// one request on one port, held until its acknowledge
	task automatic access_port(input int port, input logic write, input logic byte_op,
			input logic is_stack, input logic [2:0] size, input memory_pkg::byte_addr_t addr,
			input logic [63:0] data, output int cycles);
		logic [`EXEC_PORTS:0] acks;
		logic [`EXEC_PORTS-1:0] prev_will;
		@(posedge main_clk);
		#2;
		raise_request(port, write, byte_op, is_stack, size, addr, data);
		cycles = 0;
		acks = '0;
		prev_will = '0;
		while (acks == '0 && cycles < ACK_LIMIT) begin
			@(negedge main_clk);
			acks = {ifetch_ack, exec_ack};
			if (acks == '0) begin
				prev_will = exec_will_ack;
				cycles++;
			end
		end
		if (acks == '0) begin
			$display("no acknowledge for port %0d at address %h", port, addr);
			errors++;
		end else begin
			check_ack(port, acks, prev_will, addr);
		end
		@(posedge main_clk);
		#2;
		drop_request(port);
	endtask

	task automatic miss_then_hit_test();
		int cycles;
		int rd_before;
		rd_before = rd_count;
		access_port(FETCH_PORT, 1'b0, 1'b0, 1'b0, 3'd0, 16'h1234, '0, cycles);
		if (rd_count != rd_before + 1) begin
			$display("read miss issued %0d line reads instead of one", rd_count - rd_before);
			errors++;
		end
		if (last_rd_addr !== 12'h123) begin
			$display("[FAIL] mem_cmd.line_addr got %h expected %h", last_rd_addr, 12'h123);
			errors++;
		end
		rd_before = rd_count;
		access_port(FETCH_PORT, 1'b0, 1'b0, 1'b0, 3'd0, 16'h1238, '0, cycles);
		if (cycles != 2) begin
			$display("[FAIL] hit latency got %h expected %h", cycles, 2);
			errors++;
		end
		if (rd_count != rd_before) begin
			$display("a read hit issued a line read");
			errors++;
		end
	endtask

	task automatic word_byte_test();
		int cycles;
		access_port(1, 1'b1, 1'b0, 1'b0, 3'd0, 16'h0124, 64'hbeef, cycles);
		access_port(2, 1'b1, 1'b1, 1'b0, 3'd0, 16'h0125, 64'h005a, cycles);
		access_port(0, 1'b0, 1'b0, 1'b0, 3'd0, 16'h0124, '0, cycles);
		if (ack_line[2 * 16 +: 16] !== 16'h5aef) begin
			$display("[FAIL] rd_line word 2 got %h expected %h", ack_line[2 * 16 +: 16],
				16'h5aef);
			errors++;
		end
	endtask

	task automatic stack_test();
		int cycles;
		int offs [4];
		logic [63:0] data;
		offs = '{0, 3, 5, 4}; // offset for sizes 1 to 4, each fits its line
		for (int s = 1; s <= 4; s++) begin
			data = {rand_word(), rand_word(), rand_word(), rand_word()};
			access_port(2, 1'b1, 1'b0, 1'b1, 3'(s),
				memory_pkg::byte_addr_t'(16'h0240 + offs[s - 1] * 2), data, cycles);
			access_port(3, 1'b0, 1'b0, 1'b0, 3'd0, 16'h0240, '0, cycles);
		end
	endtask

	// all five ports at once, served strictly by priority
	task automatic priority_test();
		logic [`EXEC_PORTS:0] acks;
		logic [`EXEC_PORTS-1:0] prev_will;
		memory_pkg::byte_addr_t addrs [`EXEC_PORTS+1];
		int next_port;
		int cycles;
		@(posedge main_clk);
		#2;
		for (int p = 0; p <= FETCH_PORT; p++) begin
			addrs[p] = memory_pkg::byte_addr_t'(16'h1060 + p * 16'h1010);
			raise_request(p, 1'b0, 1'b0, 1'b0, 3'd0, addrs[p], '0);
		end
		next_port = 0;
		cycles = 0;
		prev_will = '0;
		while (next_port <= FETCH_PORT && cycles < ACK_LIMIT * 5) begin
			@(negedge main_clk);
			cycles++;
			acks = {ifetch_ack, exec_ack};
			if (acks != '0) begin
				check_ack(next_port, acks, prev_will, addrs[next_port]);
				@(posedge main_clk);
				#2;
				for (int p = 0; p <= FETCH_PORT; p++) begin
					if (acks[p]) drop_request(p);
				end
				next_port++;
				prev_will = '0;
			end else begin
				prev_will = exec_will_ack;
			end
		end
		if (next_port <= FETCH_PORT) begin
			$display("only %0d of the five ports were acknowledged", next_port);
			errors++;
		end
	endtask

	task automatic eviction_test();
		int cycles;
		int wr_before;
		int rd_before;
		logic [63:0] data;
		data = {rand_word(), rand_word(), rand_word(), rand_word()};
		access_port(0, 1'b1, 1'b0, 1'b1, 3'd4, 16'h0150, data, cycles); // dirty, then oldest
		access_port(1, 1'b0, 1'b0, 1'b0, 3'd0, 16'h0250, '0, cycles);
		access_port(1, 1'b0, 1'b0, 1'b0, 3'd0, 16'h0350, '0, cycles);
		access_port(1, 1'b0, 1'b0, 1'b0, 3'd0, 16'h0450, '0, cycles);
		wr_before = wr_count;
		access_port(1, 1'b0, 1'b0, 1'b0, 3'd0, 16'h0550, '0, cycles);
		if (wr_count != wr_before + 1) begin
			$display("eviction issued %0d line writes instead of one", wr_count - wr_before);
			errors++;
		end
		if (last_wr_addr !== 12'h015) begin
			$display("[FAIL] mem_cmd.line_addr got %h expected %h", last_wr_addr, 12'h015);
			errors++;
		end
		if (last_wr_line !== exp_lines[12'h015]) begin
			$display("[FAIL] mem_cmd.line got %h expected %h", last_wr_line, exp_lines[12'h015]);
			errors++;
		end
		rd_before = rd_count;
		access_port(2, 1'b0, 1'b0, 1'b0, 3'd0, 16'h0150, '0, cycles);
		if (rd_count != rd_before + 1) begin
			$display("the least recently used line was not replaced");
			errors++;
		end
	endtask

	initial begin
		errors = 0;
		rd_count = 0;
		wr_count = 0;
		lcg_state = 32'd90;
		last_rd_addr = '0;
		last_wr_addr = '0;
		last_wr_line = '0;
		ack_line = '0;
		rst_n = 1'b0;
		ifetch_requesting = 1'b0;
		ifetch_address = '0;
		fill_valid = 1'b0;
		fill_line = '0;
		for (int p = 0; p < `EXEC_PORTS; p++) exec_req[p] = '0;
		for (int i = 0; i < LINES; i++) begin
			for (int w = 0; w < `CACHE_LINE_WORDS; w++) mem_lines[i][w * 16 +: 16] = rand_word();
		end
		exp_lines = mem_lines;
		repeat (16) @(posedge main_clk);
		#2;
		rst_n = 1'b1;
		miss_then_hit_test();
		word_byte_test();
		stack_test();
		priority_test();
		eviction_test();
		$display("errors: %0d, line reads: %0d, line writes: %0d", errors, rd_count, wr_count);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* memory_system.sv */
`timescale 1ns/1ps
`include "memory_settings.svh"

module memory_system (
	input  logic main_clk,
	input  logic rst_n,
	input  memory_pkg::exec_req_t exec_req [`EXEC_PORTS],
	input  logic ifetch_requesting,
	input  memory_pkg::byte_addr_t ifetch_address,
	output logic [`EXEC_PORTS-1:0] exec_ack,
	output logic [`EXEC_PORTS-1:0] exec_will_ack,
	output logic ifetch_ack,
	output memory_pkg::line_t rd_line,
	output memory_pkg::mem_cmd_t mem_cmd,
	input  logic fill_valid,
	input  memory_pkg::line_t fill_line
);

	memory_pkg::access_t access;
	logic lookup;
	logic apply_write;
	logic fill_write;
	logic lru_touch;
	logic hit;
	logic victim_dirty;
	memory_pkg::way_idx_t hit_way;
	memory_pkg::way_idx_t victim_way;
	memory_pkg::tag_t victim_tag;
	memory_pkg::line_t victim_line;
	memory_pkg::line_t fill_data;
	memory_pkg::byte_mask_t wr_mask;
	memory_pkg::line_t wr_line;

	cache_controller ctrl0 (
		.main_clk(main_clk),
		.rst_n(rst_n),
		.exec_req(exec_req),
		.ifetch_requesting(ifetch_requesting),
		.ifetch_address(ifetch_address),
		.hit(hit),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.victim_line(victim_line),
		.fill_valid(fill_valid),
		.fill_line(fill_line),
		.access(access),
		.lookup(lookup),
		.apply_write(apply_write),
		.fill_write(fill_write),
		.lru_touch(lru_touch),
		.fill_data(fill_data),
		.exec_ack(exec_ack),
		.exec_will_ack(exec_will_ack),
		.ifetch_ack(ifetch_ack),
		.mem_cmd(mem_cmd)
	);

	lane_mask_builder lanes0 (
		.access(access),
		.wr_mask(wr_mask),
		.wr_line(wr_line)
	);

	cache_tags tags0 (
		.main_clk(main_clk),
		.rst_n(rst_n),
		.access(access),
		.lookup(lookup),
		.apply_write(apply_write),
		.fill_write(fill_write),
		.lru_touch(lru_touch),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag)
	);

	cache_data data0 (
		.main_clk(main_clk),
		.access(access),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.apply_write(apply_write),
		.fill_write(fill_write),
		.wr_mask(wr_mask),
		.wr_line(wr_line),
		.fill_line(fill_data),
		.rd_line(rd_line),
		.victim_line(victim_line)
	);

endmodule

/* cache_data.sv */
`timescale 1ns/1ps
`include "memory_settings.svh"

module cache_data (
	input  logic main_clk,
	input  memory_pkg::access_t access,
	input  memory_pkg::way_idx_t hit_way,
	input  memory_pkg::way_idx_t victim_way,
	input  logic apply_write,
	input  logic fill_write,
	input  memory_pkg::byte_mask_t wr_mask,
	input  memory_pkg::line_t wr_line,
	input  memory_pkg::line_t fill_line,
	output memory_pkg::line_t rd_line,
	output memory_pkg::line_t victim_line
);

	memory_pkg::line_t lines [`CACHE_SETS][`CACHE_WAYS];
	memory_pkg::set_idx_t set_idx;
	memory_pkg::line_t hit_line;
	memory_pkg::line_t merged_line; // hit line with the write applied

	assign set_idx = access.address[`CACHE_OFFSET_BITS +: `CACHE_SET_BITS];
	assign hit_line = lines[set_idx][hit_way];
	assign victim_line = lines[set_idx][victim_way]; // read for write-back

	always_comb begin
		for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
			merged_line[b*8 +: 8] = wr_mask[b] ? wr_line[b*8 +: 8] : hit_line[b*8 +: 8];
		end
	end

	always_ff @(posedge main_clk) begin
		if (fill_write) begin
			lines[set_idx][victim_way] <= fill_line;
		end else if (apply_write) begin
			lines[set_idx][hit_way] <= merged_line;
		end
	end

	// valid in the acknowledge cycle after a hit
	always_ff @(posedge main_clk) begin
		rd_line <= apply_write ? merged_line : hit_line;
	end

endmodule

/* cache_tags.sv */
`timescale 1ns/1ps
`include "memory_settings.svh"

module cache_tags (
	input  logic main_clk,
	input  logic rst_n,
	input  memory_pkg::access_t access,
	input  logic lookup,
	input  logic apply_write,
	input  logic fill_write,
	input  logic lru_touch,
	output logic hit,
	output memory_pkg::way_idx_t hit_way,
	output memory_pkg::way_idx_t victim_way,
	output logic victim_dirty,
	output memory_pkg::tag_t victim_tag
);

	memory_pkg::tag_t tags [`CACHE_SETS][`CACHE_WAYS];
	logic [`CACHE_WAYS-1:0] valid [`CACHE_SETS];
	logic [`CACHE_WAYS-1:0] dirty [`CACHE_SETS];
	memory_pkg::way_idx_t age [`CACHE_SETS][`CACHE_WAYS]; // 0 youngest, ways-1 oldest

	memory_pkg::set_idx_t set_idx;
	memory_pkg::tag_t tag;
	logic [`CACHE_WAYS-1:0] match;

	assign set_idx = access.address[`CACHE_OFFSET_BITS +: `CACHE_SET_BITS];
	assign tag = access.address[`MEM_ADDR_BITS-1 -: $bits(memory_pkg::tag_t)];

	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			match[w] = valid[set_idx][w] && (tags[set_idx][w] == tag);
		end
	end

	assign hit = lookup & (|match);

	always_comb begin
		hit_way = '0;
		for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
			if (match[w]) hit_way = memory_pkg::way_idx_t'(w);
		end
	end

	// oldest way, unless some way is still empty
	always_comb begin
		victim_way = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (age[set_idx][w] == memory_pkg::way_idx_t'(`CACHE_WAYS - 1)) begin
				victim_way = memory_pkg::way_idx_t'(w);
			end
		end
		for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
			if (!valid[set_idx][w]) victim_way = memory_pkg::way_idx_t'(w);
		end
	end

	assign victim_dirty = valid[set_idx][victim_way] & dirty[set_idx][victim_way];
	assign victim_tag = tags[set_idx][victim_way];

	always_ff @(posedge main_clk) begin
		if (!rst_n) begin
			for (int s = 0; s < `CACHE_SETS; s++) begin
				valid[s] <= '0;
				dirty[s] <= '0;
				for (int w = 0; w < `CACHE_WAYS; w++) begin
					age[s][w] <= memory_pkg::way_idx_t'(w); // any permutation works
				end
			end
		end else begin
			if (fill_write) begin
				valid[set_idx][victim_way] <= 1'b1;
				dirty[set_idx][victim_way] <= 1'b0; // fresh from memory
			end
			if (apply_write) begin
				dirty[set_idx][hit_way] <= 1'b1;
			end
			if (lru_touch) begin
				for (int w = 0; w < `CACHE_WAYS; w++) begin
					if (memory_pkg::way_idx_t'(w) == hit_way) begin
						age[set_idx][w] <= '0;
					end else if (age[set_idx][w] < age[set_idx][hit_way]) begin
						age[set_idx][w] <= age[set_idx][w] + 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge main_clk) begin
		if (fill_write) begin
			tags[set_idx][victim_way] <= tag;
		end
	end

	// fills only go to a way that missed, so a tag never sits in two ways
	a_single_hit : assert property (@(posedge main_clk) disable iff (!rst_n)
		lookup |-> $onehot0(match));

endmodule

/* lane_mask_builder.sv */
`timescale 1ns/1ps
`include "memory_settings.svh"

module lane_mask_builder (
	input  memory_pkg::access_t access,
	output memory_pkg::byte_mask_t wr_mask,
	output memory_pkg::line_t wr_line
);

	localparam int WORD_BYTES = `MEM_WORD_BITS / 8;

	logic [`CACHE_OFFSET_BITS-2:0] word_off; // word within the line
	memory_pkg::word_t byte_word; // low data byte in both halves
	int stack_end;

	assign word_off = access.address[`CACHE_OFFSET_BITS-1:1];
	assign byte_word = {access.data[0][7:0], access.data[0][7:0]};
	assign stack_end = int'(word_off) + int'(access.stack_size);

	always_comb begin
		wr_mask = '0;
		wr_line = '0;
		if (access.is_stack) begin
			// data word k goes to word_off + k
			for (int k = 0; k < 4; k++) begin
				if (k < int'(access.stack_size) && int'(word_off) + k < `CACHE_LINE_WORDS) begin
					wr_line[(int'(word_off) + k) * `MEM_WORD_BITS +: `MEM_WORD_BITS] =
						access.data[k];
					wr_mask[(int'(word_off) + k) * WORD_BYTES +: WORD_BYTES] = '1;
				end
			end
		end else begin
			// same word in every slot, the mask picks the lane
			for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
				if (access.byte_op) begin
					wr_line[w * `MEM_WORD_BITS +: `MEM_WORD_BITS] = byte_word;
				end else begin
					wr_line[w * `MEM_WORD_BITS +: `MEM_WORD_BITS] = access.data[0];
				end
			end
			if (access.byte_op) begin
				wr_mask[int'(word_off) * WORD_BYTES + int'(access.address[0])] = 1'b1;
			end else begin
				wr_mask[int'(word_off) * WORD_BYTES +: WORD_BYTES] = '1;
			end
		end
		if (!access.write) begin
			wr_mask = '0; // reads leave the line alone
		end
	end

	// executers must split stack accesses at line boundaries
	always_comb begin
		a_stack_in_line : assert (!access.is_stack || stack_end <= `CACHE_LINE_WORDS)
			else $error("stack access at %h crosses its line", access.address);
	end

endmodule

/* cache_controller.sv */
`timescale 1ns/1ps
`include "memory_settings.svh"

module cache_controller (
	input  logic main_clk,
	input  logic rst_n,
	input  memory_pkg::exec_req_t exec_req [`EXEC_PORTS],
	input  logic ifetch_requesting,
	input  memory_pkg::byte_addr_t ifetch_address,
	input  logic hit,
	input  logic victim_dirty,
	input  memory_pkg::tag_t victim_tag,
	input  memory_pkg::line_t victim_line,
	input  logic fill_valid,
	input  memory_pkg::line_t fill_line,
	output memory_pkg::access_t access,
	output logic lookup,
	output logic apply_write,
	output logic fill_write,
	output logic lru_touch,
	output memory_pkg::line_t fill_data,
	output logic [`EXEC_PORTS-1:0] exec_ack,
	output logic [`EXEC_PORTS-1:0] exec_will_ack,
	output logic ifetch_ack,
	output memory_pkg::mem_cmd_t mem_cmd
);

	memory_pkg::ctrl_state_t state;
	memory_pkg::access_t next_access;
	memory_pkg::set_idx_t set_idx;
	logic [`EXEC_PORTS:0] grant; // one-hot, top bit is the fetch port
	logic [`EXEC_PORTS:0] src; // who owns the access in flight
	logic [`EXEC_PORTS-1:0] exec_pending;
	logic [`EXEC_PORTS-1:0] exec_ack_r;
	logic ifetch_pending;
	logic ifetch_ack_r;
	logic rd_sent; // line read issued, waiting for the fill
	logic hit_now;

	// a port that is being acknowledged right now still holds its request
	always_comb begin
		for (int i = 0; i < `EXEC_PORTS; i++) begin
			exec_pending[i] = exec_req[i].requesting & ~exec_ack_r[i];
		end
	end
	assign ifetch_pending = ifetch_requesting & ~ifetch_ack_r;

	// fixed priority, executer 0 highest and fetch lowest
	always_comb begin
		grant = '0;
		next_access = '0;
		if (ifetch_pending) begin
			grant[`EXEC_PORTS] = 1'b1;
			next_access.address = ifetch_address; // plain word read
		end
		for (int i = `EXEC_PORTS - 1; i >= 0; i--) begin
			if (exec_pending[i]) begin
				grant = '0;
				grant[i] = 1'b1;
				next_access.write = exec_req[i].write;
				next_access.byte_op = exec_req[i].byte_op;
				next_access.is_stack = exec_req[i].is_stack;
				next_access.stack_size = exec_req[i].stack_size;
				next_access.address = exec_req[i].address;
				next_access.data = exec_req[i].data;
			end
		end
	end

	always_ff @(posedge main_clk) begin
		if (!rst_n) begin
			state <= memory_pkg::ST_IDLE;
			src <= '0;
			exec_ack_r <= '0;
			ifetch_ack_r <= 1'b0;
			rd_sent <= 1'b0;
		end else begin
			exec_ack_r <= '0; // acknowledges are single pulses
			ifetch_ack_r <= 1'b0;
			case (state)
				memory_pkg::ST_IDLE: begin
					if (|grant) begin
						src <= grant;
						state <= memory_pkg::ST_LOOKUP;
					end
				end
				memory_pkg::ST_LOOKUP: begin
					if (hit_now) begin
						exec_ack_r <= src[`EXEC_PORTS-1:0];
						ifetch_ack_r <= src[`EXEC_PORTS];
						state <= memory_pkg::ST_IDLE;
					end else if (victim_dirty) begin
						state <= memory_pkg::ST_WRITEBACK;
					end else begin
						state <= memory_pkg::ST_FILL;
					end
				end
				memory_pkg::ST_WRITEBACK: state <= memory_pkg::ST_FILL;
				memory_pkg::ST_FILL: begin
					if (!rd_sent) begin
						rd_sent <= 1'b1;
					end else if (fill_valid) begin
						rd_sent <= 1'b0;
						state <= memory_pkg::ST_LOOKUP; // retry, hits this time
					end
				end
				default: state <= memory_pkg::ST_IDLE;
			endcase
		end
	end

	// payload of the accepted request
	always_ff @(posedge main_clk) begin
		if (state == memory_pkg::ST_IDLE && |grant) begin
			access <= next_access;
		end
	end

	assign set_idx = access.address[`CACHE_OFFSET_BITS +: `CACHE_SET_BITS];
	assign lookup = (state == memory_pkg::ST_LOOKUP);
	assign hit_now = lookup & hit;
	assign apply_write = hit_now & access.write;
	assign lru_touch = hit_now;
	assign fill_write = (state == memory_pkg::ST_FILL) & rd_sent & fill_valid;
	assign fill_data = fill_line;

	assign exec_will_ack = hit_now ? src[`EXEC_PORTS-1:0] : '0;
	assign exec_ack = exec_ack_r;
	assign ifetch_ack = ifetch_ack_r;

	always_comb begin
		mem_cmd.wr = (state == memory_pkg::ST_WRITEBACK);
		mem_cmd.rd = (state == memory_pkg::ST_FILL) & ~rd_sent;
		mem_cmd.line = victim_line; // only meaningful with wr
		if (mem_cmd.wr) begin
			mem_cmd.line_addr = {victim_tag, set_idx}; // where the dirty line came from
		end else begin
			mem_cmd.line_addr = access.address[`MEM_ADDR_BITS-1:`CACHE_OFFSET_BITS];
		end
	end

	// one access in flight, so never two owners acknowledged together
	a_one_ack : assert property (@(posedge main_clk) disable iff (!rst_n)
		$onehot0({exec_ack, ifetch_ack}));

endmodule

/* memory_pkg.sv */
`include "memory_settings.svh"

package memory_pkg;

	typedef logic [`MEM_WORD_BITS-1:0] word_t;
	typedef logic [`MEM_ADDR_BITS-1:0] byte_addr_t;
	typedef logic [`MEM_ADDR_BITS-`CACHE_OFFSET_BITS-1:0] line_addr_t; // byte address >> 4
	typedef logic [`CACHE_SET_BITS-1:0] set_idx_t;
	typedef logic [`MEM_ADDR_BITS-`CACHE_OFFSET_BITS-`CACHE_SET_BITS-1:0] tag_t;
	typedef logic [$clog2(`CACHE_WAYS)-1:0] way_idx_t;
	typedef logic [`CACHE_LINE_WORDS*`MEM_WORD_BITS-1:0] line_t;
	typedef logic [`CACHE_LINE_BYTES-1:0] byte_mask_t;
	typedef logic [2:0] stack_size_t; // 1 to 4 words

	// one executer port, held until its acknowledge
	typedef struct packed {
		logic        requesting;
		logic        write;
		logic        byte_op;
		logic        is_stack;
		stack_size_t stack_size;
		byte_addr_t  address;
		word_t [3:0] data; // stack word k in data[k]
	} exec_req_t;

	// the access accepted by the arbiter
	typedef struct packed {
		logic        write;
		logic        byte_op;
		logic        is_stack;
		stack_size_t stack_size;
		byte_addr_t  address;
		word_t [3:0] data;
	} access_t;

	// line port toward backing memory, rd and wr are strobes
	typedef struct packed {
		logic       rd;
		logic       wr;
		line_addr_t line_addr;
		line_t      line;
	} mem_cmd_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_WRITEBACK,
		ST_FILL
	} ctrl_state_t;

endpackage

/* memory_settings.svh */
`ifndef MEMORY_SETTINGS_SVH
`define MEMORY_SETTINGS_SVH

// machine word and byte address
`define MEM_WORD_BITS 16
`define MEM_ADDR_BITS 16

// cache geometry
`define CACHE_LINE_WORDS 8
`define CACHE_SET_BITS 4 // 16 sets
`define CACHE_WAYS 4

`define EXEC_PORTS 4 // instruction fetch comes on top of these

// derived from the values above
`define CACHE_SETS (1 << `CACHE_SET_BITS)
`define CACHE_LINE_BYTES (`CACHE_LINE_WORDS * `MEM_WORD_BITS / 8)
`define CACHE_OFFSET_BITS ($clog2(`CACHE_LINE_BYTES))

`endif
